//--- source/ram_ctrl_pkg.sv
// shared widths and partition map; sram is 256K words of two 16-bit halves, mcr sits at 10x
`default_nettype none

package ram_ctrl_pkg;

   // ------------------------------------------------------------------
   // data and address widths
   // ------------------------------------------------------------------
   typedef logic [17:0] sram_addr_t;
   typedef logic [15:0] sram_half_t;
   typedef logic [31:0] word_t;
   typedef logic [48:0] mcr_word_t;
   typedef logic [13:0] mcr_addr_t;
   typedef logic [21:0] sdram_addr_t;
   typedef logic [14:0] vram_addr_t;

   // ------------------------------------------------------------------
   // sram partition map, by top address bits
   //   0xx  sdram, low 17 bits only
   //   10x  mcr, two words per microcode entry
   //   11x  vram
   // ------------------------------------------------------------------
   localparam int         SDRAM_LOW_BITS    = 17;
   localparam logic [2:0] MCR_PREFIX        = 3'b100;
   localparam logic [2:0] VRAM_PREFIX       = 3'b110;
   // returned for sdram reads above the mapped range
   localparam word_t      OUT_OF_RANGE_DATA = 32'hffff_ffff;

   // arbiter states; every non-idle state lasts one cycle
   typedef enum logic [3:0] {
      IDLE     = 4'd0,
      VGA_RD   = 4'd1,
      MCR_RD1  = 4'd2,
      MCR_RD2  = 4'd3,
      MCR_WR1  = 4'd4,
      MCR_WRW  = 4'd5,
      MCR_WR2  = 4'd6,
      SDRAM_RD = 4'd7,
      SDRAM_WR = 4'd8,
      VRAM_RD  = 4'd9,
      VRAM_WR  = 4'd10
   } arb_state_t;

endpackage

`default_nettype wire

//--- source/sram_arbiter.sv
// fixed priority, one access at a time; a port is only served while its own flag is low
`default_nettype none

module sram_arbiter
   import ram_ctrl_pkg::*;
(
   input  logic       cpu_clk,
   input  logic       reset,

   input  logic       vga_read,
   input  logic       mcr_read,
   input  logic       mcr_write,
   input  logic       sdram_read,
   input  logic       sdram_write,
   input  logic       vram_read,
   input  logic       vram_write,

   input  logic       vga_ready,
   input  logic       mcr_ready,
   input  logic       mcr_done,
   input  logic       sdram_ready,
   input  logic       sdram_done,
   input  logic       vram_ready,
   input  logic       vram_done,

   output arb_state_t state
);

   arb_state_t next_state;

   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         state <= IDLE;
      else
         state <= next_state;
   end

   // ------------------------------------------------------------------
   // next state
   // ------------------------------------------------------------------
   always_comb
   begin
      next_state = IDLE;
      case (state)
         IDLE:
         begin
            // display first, cpu video last
            if (vga_read && !vga_ready)
               next_state = VGA_RD;
            else if (mcr_read && !mcr_ready)
               next_state = MCR_RD1;
            else if (mcr_write && !mcr_done)
               next_state = MCR_WR1;
            else if (sdram_read && !sdram_ready)
               next_state = SDRAM_RD;
            else if (sdram_write && !sdram_done)
               next_state = SDRAM_WR;
            else if (vram_read && !vram_ready)
               next_state = VRAM_RD;
            else if (vram_write && !vram_done)
               next_state = VRAM_WR;
         end
         MCR_RD1: next_state = MCR_RD2;
         // high beat written, then a turnaround cycle with we_n high
         MCR_WR1: next_state = MCR_WRW;
         MCR_WRW: next_state = MCR_WR2;
         default: next_state = IDLE;
      endcase
   end

endmodule

`default_nettype wire

//--- source/sram_bus_mux.sv
// purely combinational from state; all strobes inactive and write data zero in IDLE
`default_nettype none

module sram_bus_mux
   import ram_ctrl_pkg::*;
(
   input  arb_state_t  state,
   input  sdram_addr_t sdram_addr,
   input  mcr_addr_t   mcr_addr,
   input  vram_addr_t  vga_addr,
   input  vram_addr_t  vram_addr_held,

   input  mcr_word_t   mcr_wdata,
   input  word_t       sdram_wdata,
   input  word_t       vram_wdata_held,

   output sram_addr_t  sram_addr,
   output logic        sram_oe_n,
   output logic        sram_we_n,
   output logic        sram_ce_n,
   output sram_half_t  sram_hi_wdata,
   output sram_half_t  sram_lo_wdata
);

   // ------------------------------------------------------------------
   // partitioned address
   // ------------------------------------------------------------------
   always_comb
   begin
      case (state)
         SDRAM_RD, SDRAM_WR:
            sram_addr = {1'b0, sdram_addr[SDRAM_LOW_BITS-1:0]};
         // high beat, address held through the turnaround
         MCR_RD1, MCR_WR1, MCR_WRW:
            sram_addr = {MCR_PREFIX, mcr_addr, 1'b0};
         MCR_RD2, MCR_WR2:
            sram_addr = {MCR_PREFIX, mcr_addr, 1'b1};
         VGA_RD:
            sram_addr = {VRAM_PREFIX, vga_addr};
         VRAM_RD, VRAM_WR:
            sram_addr = {VRAM_PREFIX, vram_addr_held};
         default:
            sram_addr = '0;
      endcase
   end

   // strobes, all active low
   assign sram_oe_n = !((state == VGA_RD) || (state == MCR_RD1) || (state == MCR_RD2) ||
                        (state == SDRAM_RD) || (state == VRAM_RD));
   assign sram_we_n = !((state == MCR_WR1) || (state == MCR_WR2) ||
                        (state == SDRAM_WR) || (state == VRAM_WR));
   assign sram_ce_n = (state == IDLE);

   // ------------------------------------------------------------------
   // write data split
   // ------------------------------------------------------------------
   always_comb
   begin
      sram_hi_wdata = '0;
      sram_lo_wdata = '0;
      case (state)
         // bit 48 rides alone in hi bit 0
         MCR_WR1:
         begin
            sram_hi_wdata = {15'b0, mcr_wdata[48]};
            sram_lo_wdata = mcr_wdata[47:32];
         end
         MCR_WR2:
         begin
            sram_hi_wdata = mcr_wdata[31:16];
            sram_lo_wdata = mcr_wdata[15:0];
         end
         SDRAM_WR:
         begin
            sram_hi_wdata = sdram_wdata[31:16];
            sram_lo_wdata = sdram_wdata[15:0];
         end
         VRAM_WR:
         begin
            sram_hi_wdata = vram_wdata_held[31:16];
            sram_lo_wdata = vram_wdata_held[15:0];
         end
         default:
         begin
            sram_hi_wdata = '0;
            sram_lo_wdata = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/mcr_port.sv
// two-beat microcode port; mcr_rdata is valid only while mcr_ready is high
`default_nettype none

module mcr_port
   import ram_ctrl_pkg::*;
(
   input  logic       cpu_clk,
   input  logic       reset,
   input  logic       mcr_read,
   input  logic       mcr_write,
   input  arb_state_t state,
   input  sram_half_t sram_hi_rdata,
   input  sram_half_t sram_lo_rdata,

   output mcr_word_t  mcr_rdata,
   output logic       mcr_ready,
   output logic       mcr_done
);

   // ------------------------------------------------------------------
   // read data assembly
   // ------------------------------------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      // high beat holds only bit 48 in the hi half
      if (state == MCR_RD1)
         mcr_rdata[48:32] <= {sram_hi_rdata[0], sram_lo_rdata};
      if (state == MCR_RD2)
         mcr_rdata[31:0] <= {sram_hi_rdata, sram_lo_rdata};
   end

   // ------------------------------------------------------------------
   // ready and done flags
   // ------------------------------------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         mcr_ready <= 1'b0;
         mcr_done  <= 1'b0;
      end
      else
      begin
         if (state == MCR_RD2)
            mcr_ready <= 1'b1;
         if (state == MCR_WR2)
            mcr_done <= 1'b1;

         // level dropped, flag falls next cycle
         if (!mcr_read)
            mcr_ready <= 1'b0;
         if (!mcr_write)
            mcr_done <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- source/sdram_port.sv
// only the low 17 address bits reach the sram; reads above that return all ones
`default_nettype none

module sdram_port
   import ram_ctrl_pkg::*;
(
   input  logic        cpu_clk,
   input  logic        reset,
   input  logic        sdram_read,
   input  logic        sdram_write,
   input  sdram_addr_t sdram_addr,
   input  arb_state_t  state,
   input  sram_half_t  sram_hi_rdata,
   input  sram_half_t  sram_lo_rdata,

   output word_t       sdram_rdata,
   output logic        sdram_ready,
   output logic        sdram_done
);

   logic out_of_range;

   // any of bits 21..17 set
   assign out_of_range = |sdram_addr[$bits(sdram_addr_t)-1:SDRAM_LOW_BITS];

   always_ff @(posedge cpu_clk)
   begin
      if (state == SDRAM_RD)
         sdram_rdata <= out_of_range ? OUT_OF_RANGE_DATA : {sram_hi_rdata, sram_lo_rdata};
   end

   // flags
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
      end
      else
      begin
         if (state == SDRAM_RD)
            sdram_ready <= 1'b1;
         if (state == SDRAM_WR)
            sdram_done <= 1'b1;
         if (!sdram_read)
            sdram_ready <= 1'b0;
         if (!sdram_write)
            sdram_done <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- source/vram_port.sv
// cpu address and data are sampled in every non-vram state and frozen during the access
`default_nettype none

module vram_port
   import ram_ctrl_pkg::*;
(
   input  logic       cpu_clk,
   input  logic       reset,
   input  logic       vram_read,
   input  logic       vram_write,
   input  logic       vga_read,
   input  vram_addr_t vram_addr,
   input  word_t      vram_wdata,
   input  arb_state_t state,
   input  sram_half_t sram_hi_rdata,
   input  sram_half_t sram_lo_rdata,

   output word_t      vram_rdata,
   output word_t      vga_rdata,
   output logic       vram_ready,
   output logic       vram_done,
   output logic       vga_ready,
   output vram_addr_t vram_addr_held,
   output word_t      vram_wdata_held
);

   logic vram_busy;

   assign vram_busy = (state == VRAM_RD) || (state == VRAM_WR);

   // ------------------------------------------------------------------
   // cpu address and write data holding
   // ------------------------------------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      // last value before the access is what the pins see
      if (!vram_busy)
      begin
         vram_addr_held  <= vram_addr;
         vram_wdata_held <= vram_wdata;
      end
   end

   // ------------------------------------------------------------------
   // read data, cpu and display
   // ------------------------------------------------------------------
   always_ff @(posedge cpu_clk)
   begin
      if (state == VRAM_RD)
         vram_rdata <= {sram_hi_rdata, sram_lo_rdata};
      if (state == VGA_RD)
         vga_rdata <= {sram_hi_rdata, sram_lo_rdata};
   end

   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         vram_ready <= 1'b0;
         vram_done  <= 1'b0;
         vga_ready  <= 1'b0;
      end
      else
      begin
         if (state == VRAM_RD)
            vram_ready <= 1'b1;
         if (state == VRAM_WR)
            vram_done <= 1'b1;
         if (state == VGA_RD)
            vga_ready <= 1'b1;

         // each flag follows its own level
         if (!vram_read)
            vram_ready <= 1'b0;
         if (!vram_write)
            vram_done <= 1'b0;
         if (!vga_read)
            vga_ready <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- source/ram_controller.sv
// single cpu_clk domain; clients hold address and data steady until their flag rises
`default_nettype none

module ram_controller
   import ram_ctrl_pkg::*;
(
   input  logic        cpu_clk,
   input  logic        reset,

   // display read port
   input  logic        vga_read,
   input  vram_addr_t  vga_addr,
   output word_t       vga_rdata,
   output logic        vga_ready,

   // microcode port
   input  logic        mcr_read,
   input  logic        mcr_write,
   input  mcr_addr_t   mcr_addr,
   input  mcr_word_t   mcr_wdata,
   output mcr_word_t   mcr_rdata,
   output logic        mcr_ready,
   output logic        mcr_done,

   // main memory port
   input  logic        sdram_read,
   input  logic        sdram_write,
   input  sdram_addr_t sdram_addr,
   input  word_t       sdram_wdata,
   output word_t       sdram_rdata,
   output logic        sdram_ready,
   output logic        sdram_done,

   // cpu video port
   input  logic        vram_read,
   input  logic        vram_write,
   input  vram_addr_t  vram_addr,
   input  word_t       vram_wdata,
   output word_t       vram_rdata,
   output logic        vram_ready,
   output logic        vram_done,

   // sram pins
   output sram_addr_t  sram_addr,
   output logic        sram_oe_n,
   output logic        sram_we_n,
   output logic        sram_ce_n,
   input  sram_half_t  sram_hi_rdata,
   input  sram_half_t  sram_lo_rdata,
   output sram_half_t  sram_hi_wdata,
   output sram_half_t  sram_lo_wdata
);

   arb_state_t state;
   vram_addr_t vram_addr_held;
   word_t      vram_wdata_held;

   // ------------------------------------------------------------------
   // arbiter and pin driver
   // ------------------------------------------------------------------
   sram_arbiter u_arbiter (
      .cpu_clk     (cpu_clk),
      .reset       (reset),
      .vga_read    (vga_read),
      .mcr_read    (mcr_read),
      .mcr_write   (mcr_write),
      .sdram_read  (sdram_read),
      .sdram_write (sdram_write),
      .vram_read   (vram_read),
      .vram_write  (vram_write),
      .vga_ready   (vga_ready),
      .mcr_ready   (mcr_ready),
      .mcr_done    (mcr_done),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done),
      .vram_ready  (vram_ready),
      .vram_done   (vram_done),
      .state       (state)
   );

   sram_bus_mux u_bus_mux (
      .state           (state),
      .sdram_addr      (sdram_addr),
      .mcr_addr        (mcr_addr),
      .vga_addr        (vga_addr),
      .vram_addr_held  (vram_addr_held),
      .mcr_wdata       (mcr_wdata),
      .sdram_wdata     (sdram_wdata),
      .vram_wdata_held (vram_wdata_held),
      .sram_addr       (sram_addr),
      .sram_oe_n       (sram_oe_n),
      .sram_we_n       (sram_we_n),
      .sram_ce_n       (sram_ce_n),
      .sram_hi_wdata   (sram_hi_wdata),
      .sram_lo_wdata   (sram_lo_wdata)
   );

   // ------------------------------------------------------------------
   // client ports
   // ------------------------------------------------------------------
   mcr_port u_mcr_port (
      .cpu_clk       (cpu_clk),
      .reset         (reset),
      .mcr_read      (mcr_read),
      .mcr_write     (mcr_write),
      .state         (state),
      .sram_hi_rdata (sram_hi_rdata),
      .sram_lo_rdata (sram_lo_rdata),
      .mcr_rdata     (mcr_rdata),
      .mcr_ready     (mcr_ready),
      .mcr_done      (mcr_done)
   );

   sdram_port u_sdram_port (
      .cpu_clk       (cpu_clk),
      .reset         (reset),
      .sdram_read    (sdram_read),
      .sdram_write   (sdram_write),
      .sdram_addr    (sdram_addr),
      .state         (state),
      .sram_hi_rdata (sram_hi_rdata),
      .sram_lo_rdata (sram_lo_rdata),
      .sdram_rdata   (sdram_rdata),
      .sdram_ready   (sdram_ready),
      .sdram_done    (sdram_done)
   );

   vram_port u_vram_port (
      .cpu_clk         (cpu_clk),
      .reset           (reset),
      .vram_read       (vram_read),
      .vram_write      (vram_write),
      .vga_read        (vga_read),
      .vram_addr       (vram_addr),
      .vram_wdata      (vram_wdata),
      .state           (state),
      .sram_hi_rdata   (sram_hi_rdata),
      .sram_lo_rdata   (sram_lo_rdata),
      .vram_rdata      (vram_rdata),
      .vga_rdata       (vga_rdata),
      .vram_ready      (vram_ready),
      .vram_done       (vram_done),
      .vga_ready       (vga_ready),
      .vram_addr_held  (vram_addr_held),
      .vram_wdata_held (vram_wdata_held)
   );

endmodule

`default_nettype wire

//--- bench/sram_model.sv
// async 256K x 32 sram as two 16-bit halves; a write is taken 1 time unit after we_n falls
`default_nettype none

module sram_model
   import ram_ctrl_pkg::*;
(
   input  sram_addr_t sram_addr,
   input  logic       sram_ce_n,
   input  logic       sram_oe_n,
   input  logic       sram_we_n,
   input  sram_half_t sram_hi_wdata,
   input  sram_half_t sram_lo_wdata,
   output sram_half_t sram_hi_rdata,
   output sram_half_t sram_lo_rdata
);

   sram_half_t mem_hi [0:262143];
   sram_half_t mem_lo [0:262143];

   // read path, zero when the chip is not selected for reading
   assign sram_hi_rdata = (!sram_ce_n && !sram_oe_n) ? mem_hi[sram_addr] : '0;
   assign sram_lo_rdata = (!sram_ce_n && !sram_oe_n) ? mem_lo[sram_addr] : '0;

   // ------------------------------------------------------------------
   // write path
   // ------------------------------------------------------------------
   always @(negedge sram_we_n)
   begin
      // address and data settle with the strobe, so sample mid-pulse
      #1;
      if (!sram_we_n && !sram_ce_n)
      begin
         mem_hi[sram_addr] = sram_hi_wdata;
         mem_lo[sram_addr] = sram_lo_wdata;
      end
   end

endmodule

`default_nettype wire

//--- bench/tb_ram_controller.sv
// run from the project root; one request per pattern, except the vga plus sdram pair kind
`default_nettype none

module tb_ram_controller
   import ram_ctrl_pkg::*;
();

   // pattern kinds, as in the first column of the pattern file
   localparam logic [3:0] K_END      = 4'd0;
   localparam logic [3:0] K_MCR_WR   = 4'd1;
   localparam logic [3:0] K_MCR_RD   = 4'd2;
   localparam logic [3:0] K_SDRAM_WR = 4'd3;
   localparam logic [3:0] K_SDRAM_RD = 4'd4;
   localparam logic [3:0] K_VRAM_WR  = 4'd5;
   localparam logic [3:0] K_VRAM_RD  = 4'd6;
   localparam logic [3:0] K_VGA_RD   = 4'd7;
   localparam logic [3:0] K_PAIR     = 4'd8;

   localparam int MAX_PATTERNS = 32;
   localparam int FLAG_WAIT    = 8;
   localparam int HOLD_CYCLES  = 3;

   logic        cpu_clk = 1'b0;
   logic        reset;
   logic        vga_read;
   vram_addr_t  vga_addr;
   word_t       vga_rdata;
   logic        vga_ready;
   logic        mcr_read;
   logic        mcr_write;
   mcr_addr_t   mcr_addr;
   mcr_word_t   mcr_wdata;
   mcr_word_t   mcr_rdata;
   logic        mcr_ready;
   logic        mcr_done;
   logic        sdram_read;
   logic        sdram_write;
   sdram_addr_t sdram_addr;
   word_t       sdram_wdata;
   word_t       sdram_rdata;
   logic        sdram_ready;
   logic        sdram_done;
   logic        vram_read;
   logic        vram_write;
   vram_addr_t  vram_addr;
   word_t       vram_wdata;
   word_t       vram_rdata;
   logic        vram_ready;
   logic        vram_done;
   sram_addr_t  sram_addr;
   logic        sram_oe_n;
   logic        sram_we_n;
   logic        sram_ce_n;
   sram_half_t  sram_hi_rdata;
   sram_half_t  sram_lo_rdata;
   sram_half_t  sram_hi_wdata;
   sram_half_t  sram_lo_wdata;

   // four words per pattern: kind, address, write data, expected
   logic [63:0] pat_mem [0:4*MAX_PATTERNS-1];
   int          pattern_count;
   int          pass_count  = 0;
   int          fail_count  = 0;
   int          cycle_count = 0;
   int          cycle_limit = 100;

   ram_controller uut (.*);

   sram_model u_sram (.*);

   always
   begin
      #2 cpu_clk = ~cpu_clk;
   end

   always @(posedge cpu_clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   function automatic string kind_name(input logic [3:0] kind);
      case (kind)
         K_MCR_WR:   return "mcr_write";
         K_MCR_RD:   return "mcr_read";
         K_SDRAM_WR: return "sdram_write";
         K_SDRAM_RD: return "sdram_read";
         K_VRAM_WR:  return "vram_write";
         K_VRAM_RD:  return "vram_read";
         K_VGA_RD:   return "vga_read";
         K_PAIR:     return "vga_sdram_pair";
         default:    return "unknown";
      endcase
   endfunction

   function automatic logic is_read(input logic [3:0] kind);
      return (kind != K_MCR_WR) && (kind != K_SDRAM_WR) && (kind != K_VRAM_WR);
   endfunction

   // true when every flag that answers this kind sits at level
   function automatic logic flags_at(input logic [3:0] kind, input logic level);
      case (kind)
         K_MCR_WR:   return mcr_done === level;
         K_MCR_RD:   return mcr_ready === level;
         K_SDRAM_WR: return sdram_done === level;
         K_SDRAM_RD: return sdram_ready === level;
         K_VRAM_WR:  return vram_done === level;
         K_VRAM_RD:  return vram_ready === level;
         K_VGA_RD:   return vga_ready === level;
         K_PAIR:     return (vga_ready === level) && (sdram_ready === level);
         default:    return 1'b0;
      endcase
   endfunction

   function automatic logic [63:0] read_data(input logic [3:0] kind);
      case (kind)
         K_MCR_RD:   return {15'b0, mcr_rdata};
         K_SDRAM_RD: return {32'b0, sdram_rdata};
         K_VRAM_RD:  return {32'b0, vram_rdata};
         K_VGA_RD:   return {32'b0, vga_rdata};
         K_PAIR:     return {vga_rdata, sdram_rdata};
         default:    return 64'b0;
      endcase
   endfunction

   task automatic drive_request(input logic [3:0] kind, input logic [63:0] addr,
                                input logic [63:0] wdata, input logic level);
      @(posedge cpu_clk);
      case (kind)
         K_MCR_WR:
         begin
            mcr_addr  <= addr[13:0];
            mcr_wdata <= wdata[48:0];
            mcr_write <= level;
         end
         K_MCR_RD:
         begin
            mcr_addr <= addr[13:0];
            mcr_read <= level;
         end
         K_SDRAM_WR:
         begin
            sdram_addr  <= addr[21:0];
            sdram_wdata <= wdata[31:0];
            sdram_write <= level;
         end
         K_SDRAM_RD:
         begin
            sdram_addr <= addr[21:0];
            sdram_read <= level;
         end
         K_VRAM_WR:
         begin
            vram_addr  <= addr[14:0];
            vram_wdata <= wdata[31:0];
            vram_write <= level;
         end
         K_VRAM_RD:
         begin
            vram_addr <= addr[14:0];
            vram_read <= level;
         end
         K_VGA_RD:
         begin
            vga_addr <= addr[14:0];
            vga_read <= level;
         end
         // both levels on the same edge
         K_PAIR:
         begin
            sdram_addr <= addr[21:0];
            vga_addr   <= wdata[14:0];
            sdram_read <= level;
            vga_read   <= level;
         end
      endcase
   endtask

   task automatic wait_flags(input logic [3:0] kind, input logic level, output logic seen);
      int count;
      count = 0;
      seen  = 1'b0;
      while ((count < FLAG_WAIT) && !seen)
      begin
         @(negedge cpu_clk);
         seen  = flags_at(kind, level);
         count = count + 1;
      end
   endtask

   task automatic report_test(input string name, input logic ok);
      if (ok)
      begin
         pass_count = pass_count + 1;
         $display("%s: ok", name);
      end
      else
      begin
         fail_count = fail_count + 1;
         $display("%s: failed", name);
      end
   endtask

   // ------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------
   task automatic check_reset_state();
      logic [6:0] flags;
      logic [2:0] strobes;
      logic       ok;
      flags   = {vga_ready, mcr_ready, mcr_done, sdram_ready, sdram_done,
                 vram_ready, vram_done};
      strobes = {sram_ce_n, sram_oe_n, sram_we_n};
      ok      = 1'b1;
      if (flags !== 7'b0)
      begin
         $display("mismatch reset_flags expected %b actual %b", 7'b0, flags);
         ok = 1'b0;
      end
      if (strobes !== 3'b111)
      begin
         $display("mismatch reset_strobes expected %b actual %b", 3'b111, strobes);
         ok = 1'b0;
      end
      report_test("reset_state", ok);
   endtask

   task automatic run_pattern(input int idx);
      logic [6:0]  base;
      logic [3:0]  kind;
      logic [63:0] addr;
      logic [63:0] wdata;
      logic [63:0] expected;
      logic [63:0] actual;
      logic        seen;
      logic        ok;
      string       name;
      int          hold;
      base     = 7'(4 * idx);
      kind     = pat_mem[base][3:0];
      addr     = pat_mem[base + 7'd1];
      wdata    = pat_mem[base + 7'd2];
      expected = pat_mem[base + 7'd3];
      name     = $sformatf("%0d_%s", idx, kind_name(kind));
      ok       = 1'b1;

      drive_request(kind, addr, wdata, 1'b1);
      wait_flags(kind, 1'b1, seen);
      if (!seen)
      begin
         $display("%s: flag never rose within %0d cycles", name, FLAG_WAIT);
         ok = 1'b0;
      end
      else if (is_read(kind))
      begin
         actual = read_data(kind);
         if (actual !== expected)
         begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            ok = 1'b0;
         end
      end

      // a held level keeps both ready flags up
      if (seen && (kind == K_PAIR))
      begin
         for (hold = 0; hold < HOLD_CYCLES; hold++)
         begin
            @(negedge cpu_clk);
            if (!flags_at(kind, 1'b1))
            begin
               $display("%s: a ready flag fell while its level was still held", name);
               ok = 1'b0;
            end
         end
      end

      drive_request(kind, addr, wdata, 1'b0);
      wait_flags(kind, 1'b0, seen);
      if (!seen)
      begin
         $display("%s: flag never fell after the level was dropped", name);
         ok = 1'b0;
      end
      report_test(name, ok);
   endtask

   initial
   begin
      int i;
      reset       <= 1'b1;
      vga_read    <= 1'b0;
      vga_addr    <= '0;
      mcr_read    <= 1'b0;
      mcr_write   <= 1'b0;
      mcr_addr    <= '0;
      mcr_wdata   <= '0;
      sdram_read  <= 1'b0;
      sdram_write <= 1'b0;
      sdram_addr  <= '0;
      sdram_wdata <= '0;
      vram_read   <= 1'b0;
      vram_write  <= 1'b0;
      vram_addr   <= '0;
      vram_wdata  <= '0;

      for (i = 0; i < 4 * MAX_PATTERNS; i++)
         pat_mem[7'(i)] = '0;
      $readmemh("bench/ram_ctrl_patterns.txt", pat_mem);
      pattern_count = 0;
      while ((pattern_count < MAX_PATTERNS) &&
             (pat_mem[7'(4 * pattern_count)][3:0] != K_END))
         pattern_count = pattern_count + 1;
      cycle_limit = pattern_count * 16 + 100;

      repeat (5) @(posedge cpu_clk);
      reset <= 1'b0;
      @(negedge cpu_clk);
      check_reset_state();

      if (pattern_count == 0)
      begin
         $display("no patterns were read from bench/ram_ctrl_patterns.txt");
         fail_count = fail_count + 1;
      end
      for (i = 0; i < pattern_count; i++)
         run_pattern(i);

      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/ram_ctrl_patterns.txt
// columns, all hex: kind address write_data expected_read_data
// kinds 1 mcr wr, 2 mcr rd, 3 sdram wr, 4 sdram rd, 5 vram wr, 6 vram rd, 7 vga rd, 8 pair
// pair: address is the sdram address, write_data the vga address, expected {vga, sdram}
1 0005 1a5a5c3c30f0f 0
2 0005 0 1a5a5c3c30f0f
1 3fff 0fedcba987654 0
2 3fff 0 0fedcba987654
3 001234 deadbeef 0
4 001234 0 deadbeef
4 021234 0 ffffffff
4 201234 0 ffffffff
3 01ffff 13572468 0
4 01ffff 0 13572468
5 7abc cafef00d 0
6 7abc 0 cafef00d
7 7abc 0 cafef00d
3 000123 11111111 0
1 0123 1222222222222 0
5 0123 33333333 0
4 000123 0 11111111
2 0123 0 1222222222222
6 0123 0 33333333
7 0123 0 33333333
4 020123 0 ffffffff
8 001234 7abc cafef00ddeadbeef
8 01ffff 0123 3333333313572468
5 0000 0badf00d 0
8 000123 0000 0badf00d11111111

//--- filelist.f
source/ram_ctrl_pkg.sv
source/sram_arbiter.sv
source/sram_bus_mux.sv
source/mcr_port.sv
source/sdram_port.sv
source/vram_port.sv
source/ram_controller.sv
bench/sram_model.sv
bench/tb_ram_controller.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator and run from the project root; fails unless the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f filelist.f --top-module tb_ram_controller -Mdir obj_dir &&
./obj_dir/Vtb_ram_controller | tee /dev/stderr | grep -qx "SIMULATION PASSED" &&
echo "run_sim: ok" ||
{ echo "run_sim: failed"; exit 1; }
